/* clkmgr_pkg.sv */
`default_nettype none

package clkmgr_pkg;

	//////////////////////////////////////////////////////////////////////
	// sizes and timing
	//////////////////////////////////////////////////////////////////////

	localparam int CMD_CREDITS    = 2;   // command queue depth
	localparam int CMD_QPTR_W     = $clog2(CMD_CREDITS);
	localparam int RSP_CRED_W     = 4;   // response credit counter
	localparam int RST_CYCLES     = 16;  // mmcm reset pulse length
	localparam int LOCK_CYCLES    = 32;  // model lock delay, per mmcm
	localparam int LOCK_TIMEOUT   = 120; // counted from end of reset
	localparam int PS_DONE_CYCLES = 12;  // psen to psdone
	localparam int RSP_DATA_W     = 14;
	localparam int RSP_POS_W      = 11;  // position bits in status data

	//////////////////////////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		OP_RESET  = 2'd0,
		OP_SHIFT  = 2'd1,
		OP_STATUS = 2'd2
	} opcode_t;

	// reset: bit 0 mult path, bit 1 mult mmcm power down
	// shift: signed step count
	typedef logic [7:0] cmd_arg_t;

	typedef logic signed [15:0] phase_pos_t;
	typedef logic [15:0] rsp_t;           // {code, data}
	typedef logic [RSP_DATA_W-1:0] rsp_data_t;
	typedef logic [7:0] cyc_cnt_t;        // holds every timing constant

	typedef enum logic [1:0] {
		RC_OK         = 2'd0,
		RC_TIMEOUT    = 2'd1,
		RC_NOT_LOCKED = 2'd2
	} rsp_code_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_RESET,
		ST_WAIT_LOCK,
		ST_SHIFT,
		ST_RESPOND
	} ctrl_state_t;

endpackage

`default_nettype wire

/* ps_if.sv */
`timescale 1ns/100ps
`default_nettype none

// controller to phase stepper
interface ps_if;
	import clkmgr_pkg::*;

	logic       start;    // one cycle
	phase_pos_t steps;    // signed, valid with start
	logic       busy;
	logic       done;     // one cycle
	phase_pos_t position; // running phase position

	modport ctrl (
		output start,
		output steps,
		input  busy,
		input  done,
		input  position
	);

	modport stepper (
		input  start,
		input  steps,
		output busy,
		output done,
		output position
	);
endinterface

`default_nettype wire

/* clk_gen_model.sv */
`timescale 1ns/100ps
`default_nettype none

module clk_gen_model (
	input  wire        clk_i,
	input  wire        rst_n_i,
	input  wire  [2:0] ctrl_i,       // {mult_sel, pwrdwn, reset}
	input  wire  [1:0] phase_ctrl_i, // {psincdec, psen}
	output logic [1:0] status_o,     // {mult locked, main locked}
	output logic       phase_ctrl_o  // psdone
);
	import clkmgr_pkg::*;

	logic       mmcm_rst;
	logic       mult_pwrdwn;
	logic       mult_sel;
	logic       psen;
	logic       mult_locked;
	logic       main_locked;
	logic       ps_accept;
	cyc_cnt_t   mult_cnt_q;
	cyc_cnt_t   main_cnt_q;
	cyc_cnt_t   ps_cnt_q;

	assign mmcm_rst    = ctrl_i[0];
	assign mult_pwrdwn = ctrl_i[1];
	assign mult_sel    = ctrl_i[2];
	assign psen        = phase_ctrl_i[0];

	assign mult_locked = (mult_cnt_q == cyc_cnt_t'(LOCK_CYCLES));
	assign main_locked = (main_cnt_q == cyc_cnt_t'(LOCK_CYCLES));
	assign status_o    = {mult_locked, main_locked};

	// multiplier mmcm
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mult_cnt_q <= '0;
		end else if (mmcm_rst || mult_pwrdwn) begin
			mult_cnt_q <= '0;
		end else if (!mult_locked) begin
			mult_cnt_q <= mult_cnt_q + 1'b1;
		end
	end

	// main mmcm, chained behind the multiplier when mult_sel is set
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			main_cnt_q <= '0;
		end else if (mmcm_rst) begin
			main_cnt_q <= '0;
		end else if (mult_sel && !mult_locked) begin
			main_cnt_q <= '0; // no input clock yet
		end else if (!main_locked) begin
			main_cnt_q <= main_cnt_q + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// fine phase shift
	//////////////////////////////////////////////////////////////////////

	assign ps_accept    = psen && (ps_cnt_q == '0); // psen mid-step is dropped
	assign phase_ctrl_o = (ps_cnt_q == cyc_cnt_t'(1));

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ps_cnt_q <= '0;
		end else begin
			if (ps_accept) begin
				ps_cnt_q <= cyc_cnt_t'(PS_DONE_CYCLES);
			end else if (ps_cnt_q != '0) begin
				ps_cnt_q <= ps_cnt_q - 1'b1;
			end
		end
	end
endmodule

`default_nettype wire

/* phase_stepper.sv */
`timescale 1ns/100ps
`default_nettype none

module phase_stepper (
	input  wire   clk_i,
	input  wire   rst_n_i,
	ps_if.stepper ps,
	output logic  psen_o,
	output logic  psincdec_o,
	input  wire   psdone_i
);
	import clkmgr_pkg::*;

	phase_pos_t steps_abs;
	phase_pos_t remain_q;  // steps still to issue, incl. the one in flight
	phase_pos_t pos_q;
	logic       busy_q;
	logic       done_q;
	logic       psen_q;
	logic       incdec_q;

	assign steps_abs = (ps.steps < 0) ? -ps.steps : ps.steps;

	assign ps.busy     = busy_q;
	assign ps.done     = done_q;
	assign ps.position = pos_q;
	assign psen_o      = psen_q;
	assign psincdec_o  = incdec_q;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			remain_q <= '0;
			pos_q    <= '0;
			busy_q   <= 1'b0;
			done_q   <= 1'b0;
			psen_q   <= 1'b0;
			incdec_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			psen_q <= 1'b0;
			if (ps.start && !busy_q) begin
				incdec_q <= (ps.steps >= 0); // positive counts increment
				remain_q <= steps_abs;
				if (steps_abs == '0) begin
					done_q <= 1'b1;
				end else begin
					busy_q <= 1'b1;
					psen_q <= 1'b1; // first step
				end
			end else if (busy_q && psdone_i) begin
				pos_q    <= incdec_q ? pos_q + 1'b1 : pos_q - 1'b1;
				remain_q <= remain_q - 1'b1;
				if (remain_q == phase_pos_t'(1)) begin
					busy_q <= 1'b0;
					done_q <= 1'b1;
				end else begin
					psen_q <= 1'b1; // next step right after done
				end
			end
		end
	end
endmodule

`default_nettype wire

/* lock_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module lock_monitor (
	input  wire  clk_i,
	input  wire  rst_n_i,
	input  wire  restart_i,
	input  wire  mult_sel_i,
	input  wire  locked_main_i,
	input  wire  locked_mult_i,
	output logic mmcm_rst_o,
	output logic finished_o,
	output logic timed_out_o
);
	import clkmgr_pkg::*;

	cyc_cnt_t cnt_q;
	logic     rst_q;
	logic     wait_q;
	logic     fin_q;
	logic     to_q;
	logic     lock_ok;

	// mult path needs both clocks
	assign lock_ok = locked_main_i && (!mult_sel_i || locked_mult_i);

	assign mmcm_rst_o  = rst_q;
	assign finished_o  = fin_q;
	assign timed_out_o = to_q;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cnt_q  <= '0;
			rst_q  <= 1'b0;
			wait_q <= 1'b0;
			fin_q  <= 1'b0;
			to_q   <= 1'b0;
		end else begin
			fin_q <= 1'b0;
			if (restart_i) begin
				cnt_q  <= '0;
				rst_q  <= 1'b1;
				wait_q <= 1'b0;
				to_q   <= 1'b0;
			end else if (rst_q) begin
				if (cnt_q == cyc_cnt_t'(RST_CYCLES - 1)) begin
					rst_q  <= 1'b0;
					wait_q <= 1'b1;
					cnt_q  <= '0;
				end else begin
					cnt_q <= cnt_q + 1'b1;
				end
			end else if (wait_q) begin
				if (lock_ok) begin
					wait_q <= 1'b0;
					fin_q  <= 1'b1;
				end else if (cnt_q == cyc_cnt_t'(LOCK_TIMEOUT - 1)) begin
					wait_q <= 1'b0;
					fin_q  <= 1'b1;
					to_q   <= 1'b1; // held until next restart
				end else begin
					cnt_q <= cnt_q + 1'b1;
				end
			end
		end
	end
endmodule

`default_nettype wire

/* clk_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module clk_ctrl (
	input  wire                  clk_i,
	input  wire                  rst_n_i,
	input  wire                  cmd_valid_i,
	input  wire clkmgr_pkg::opcode_t  cmd_op_i,
	input  wire clkmgr_pkg::cmd_arg_t cmd_arg_i,
	output logic                 cmd_credit_o,
	input  wire                  rsp_credit_i,
	output logic                 rsp_valid_o,
	output clkmgr_pkg::rsp_t     rsp_o,
	ps_if.ctrl                   ps,
	output logic                 restart_o,
	output logic                 mult_sel_o,
	output logic                 pwrdwn_o,
	input  wire                  finished_i,
	input  wire                  timed_out_i,
	input  wire                  locked_main_i,
	input  wire                  locked_mult_i
);
	import clkmgr_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// command queue
	//////////////////////////////////////////////////////////////////////

	opcode_t               q_op [CMD_CREDITS];
	cmd_arg_t              q_arg [CMD_CREDITS];
	logic [CMD_QPTR_W-1:0] wr_ptr_q;
	logic [CMD_QPTR_W-1:0] rd_ptr_q;
	logic [CMD_QPTR_W:0]   q_cnt_q;
	logic                  pop;
	opcode_t               head_op;
	cmd_arg_t              head_arg;
	logic                  credit_q;

	ctrl_state_t           state_q;
	rsp_code_t             code_q;
	phase_pos_t            steps_q;
	logic                  start_q;
	logic                  mult_sel_q;
	logic                  pwrdwn_q;
	logic [RSP_CRED_W-1:0] rsp_cred_q;
	logic                  rsp_send;
	logic                  rsp_valid_q;
	rsp_data_t             rsp_data;

	assign head_op  = q_op[rd_ptr_q];
	assign head_arg = q_arg[rd_ptr_q];
	assign pop      = (state_q == ST_IDLE) && (q_cnt_q != '0) && !ps.busy;

	always_ff @(posedge clk_i) begin
		if (cmd_valid_i) begin
			q_op[wr_ptr_q]  <= cmd_op_i;
			q_arg[wr_ptr_q] <= cmd_arg_i;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			q_cnt_q  <= '0;
			credit_q <= 1'b0;
		end else begin
			credit_q <= pop; // one credit back per removed command
			if (cmd_valid_i) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			if (cmd_valid_i && !pop) begin
				q_cnt_q <= q_cnt_q + 1'b1;
			end else if (pop && !cmd_valid_i) begin
				q_cnt_q <= q_cnt_q - 1'b1;
			end
		end
	end

	assign cmd_credit_o = credit_q;

	//////////////////////////////////////////////////////////////////////
	// sequencing
	//////////////////////////////////////////////////////////////////////

	assign restart_o  = (state_q == ST_RESET);
	assign mult_sel_o = mult_sel_q;
	assign pwrdwn_o   = pwrdwn_q;
	assign ps.start   = start_q;
	assign ps.steps   = steps_q;

	always_ff @(posedge clk_i) begin
		if (pop) begin
			steps_q <= phase_pos_t'(signed'(head_arg)); // sign extend
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q    <= ST_IDLE;
			code_q     <= RC_OK;
			start_q    <= 1'b0;
			mult_sel_q <= 1'b0;
			pwrdwn_q   <= 1'b0;
		end else begin
			start_q <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (pop) begin
						case (head_op)
							OP_RESET: begin
								mult_sel_q <= head_arg[0];
								pwrdwn_q   <= head_arg[1];
								state_q    <= ST_RESET;
							end
							OP_SHIFT: begin
								if (!locked_main_i) begin
									code_q  <= RC_NOT_LOCKED; // no steps taken
									state_q <= ST_RESPOND;
								end else begin
									start_q <= 1'b1;
									state_q <= ST_SHIFT;
								end
							end
							OP_STATUS: begin
								code_q  <= timed_out_i ? RC_TIMEOUT : RC_OK;
								state_q <= ST_RESPOND;
							end
							default: begin
								code_q  <= RC_OK;
								state_q <= ST_RESPOND;
							end
						endcase
					end
				end
				ST_RESET: state_q <= ST_WAIT_LOCK; // restart pulse out
				ST_WAIT_LOCK: begin
					if (finished_i) begin
						code_q  <= timed_out_i ? RC_TIMEOUT : RC_OK;
						state_q <= ST_RESPOND;
					end
				end
				ST_SHIFT: begin
					if (ps.done) begin
						code_q  <= RC_OK;
						state_q <= ST_RESPOND;
					end
				end
				ST_RESPOND: begin
					if (rsp_send) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// response
	//////////////////////////////////////////////////////////////////////

	// {main lock, mult lock, timed out, position}
	assign rsp_data = {locked_main_i, locked_mult_i, timed_out_i, ps.position[RSP_POS_W-1:0]};
	assign rsp_send = (state_q == ST_RESPOND) && (rsp_cred_q != '0);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rsp_cred_q  <= '0;
			rsp_valid_q <= 1'b0;
		end else begin
			rsp_valid_q <= rsp_send;
			if (rsp_credit_i && !rsp_send) begin
				rsp_cred_q <= rsp_cred_q + 1'b1;
			end else if (rsp_send && !rsp_credit_i) begin
				rsp_cred_q <= rsp_cred_q - 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rsp_send) begin
			rsp_o <= {code_q, rsp_data};
		end
	end

	assign rsp_valid_o = rsp_valid_q;
endmodule

`default_nettype wire

/* clkmgr_top.sv */
`timescale 1ns/100ps
`default_nettype none

module clkmgr_top (
	input  wire                       clk_i,
	input  wire                       rst_n_i,
	input  wire                       cmd_valid_i,
	input  wire clkmgr_pkg::opcode_t  cmd_op_i,
	input  wire clkmgr_pkg::cmd_arg_t cmd_arg_i,
	output logic                      cmd_credit_o,
	input  wire                       rsp_credit_i,
	output logic                      rsp_valid_o,
	output clkmgr_pkg::rsp_t          rsp_o,
	output logic                      locked_o,
	output logic                      psen_o
);
	ps_if ps ();

	logic       restart;
	logic       mult_sel;
	logic       pwrdwn;
	logic       finished;
	logic       timed_out;
	logic       mmcm_rst;
	logic [1:0] gen_status; // {mult, main}
	logic       psen;
	logic       psincdec;
	logic       psdone;

	assign locked_o = gen_status[0];
	assign psen_o   = psen;

	clk_ctrl u_ctrl (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.cmd_valid_i   (cmd_valid_i),
		.cmd_op_i      (cmd_op_i),
		.cmd_arg_i     (cmd_arg_i),
		.cmd_credit_o  (cmd_credit_o),
		.rsp_credit_i  (rsp_credit_i),
		.rsp_valid_o   (rsp_valid_o),
		.rsp_o         (rsp_o),
		.ps            (ps.ctrl),
		.restart_o     (restart),
		.mult_sel_o    (mult_sel),
		.pwrdwn_o      (pwrdwn),
		.finished_i    (finished),
		.timed_out_i   (timed_out),
		.locked_main_i (gen_status[0]),
		.locked_mult_i (gen_status[1])
	);

	phase_stepper u_stepper (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.ps         (ps.stepper),
		.psen_o     (psen),
		.psincdec_o (psincdec),
		.psdone_i   (psdone)
	);

	lock_monitor u_lock_mon (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.restart_i     (restart),
		.mult_sel_i    (mult_sel),
		.locked_main_i (gen_status[0]),
		.locked_mult_i (gen_status[1]),
		.mmcm_rst_o    (mmcm_rst),
		.finished_o    (finished),
		.timed_out_o   (timed_out)
	);

	clk_gen_model u_gen (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.ctrl_i       ({mult_sel, pwrdwn, mmcm_rst}),
		.phase_ctrl_i ({psincdec, psen}),
		.status_o     (gen_status),
		.phase_ctrl_o (psdone)
	);
endmodule

`default_nettype wire

/* clkmgr_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

// handshake checks, bound into clk_ctrl and clk_gen_model
module clkmgr_asserts (
	input wire                       clk_i,
	input wire                       rst_n_i,
	input wire                       cmd_valid_i,
	input wire                       cmd_credit_i,
	input wire                       psen_i,
	input wire clkmgr_pkg::cyc_cnt_t ps_cnt_i,
	input wire                       psdone_i
);
	import clkmgr_pkg::*;

	logic [3:0] held_q;   // commands taken, credit not yet back

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			held_q <= '0;
		end else if (cmd_valid_i && !cmd_credit_i) begin
			held_q <= held_q + 1'b1;
		end else if (cmd_credit_i && !cmd_valid_i) begin
			held_q <= held_q - 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// command credits
	//////////////////////////////////////////////////////////////////////

	a_credit_owed: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		cmd_credit_i |-> (held_q != '0))
		else $error("command credit returned with no command held");

	a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		held_q <= 4'(CMD_CREDITS))
		else $error("more commands held than credits exist");

	//////////////////////////////////////////////////////////////////////
	// phase shift
	//////////////////////////////////////////////////////////////////////

	a_psdone_after_psen: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$past(psen_i, PS_DONE_CYCLES) |-> psdone_i)
		else $error("psdone missing after psen");

	a_psdone_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		psdone_i |-> $past(psen_i, PS_DONE_CYCLES))
		else $error("psdone without a matching psen");

	a_psen_in_flight: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		psen_i |-> (ps_cnt_i == '0))
		else $error("psen raised while a step is in flight");
endmodule

bind clk_ctrl clkmgr_asserts u_ctrl_asserts (
	.clk_i        (clk_i),
	.rst_n_i      (rst_n_i),
	.cmd_valid_i  (cmd_valid_i),
	.cmd_credit_i (cmd_credit_o),
	.psen_i       (1'b0),
	.ps_cnt_i     (8'd0),
	.psdone_i     (1'b0)
);

bind clk_gen_model clkmgr_asserts u_gen_asserts (
	.clk_i        (clk_i),
	.rst_n_i      (rst_n_i),
	.cmd_valid_i  (1'b0),
	.cmd_credit_i (1'b0),
	.psen_i       (phase_ctrl_i[0]),
	.ps_cnt_i     (ps_cnt_q),
	.psdone_i     (phase_ctrl_o)
);

`default_nettype wire

/* tb_clk_src.sv */
`timescale 1ns/100ps
`default_nettype none

// 10 ns clock, reset held low for the first 8 cycles
module tb_clk_src (
	output logic clk_o,
	output logic rst_n_o
);
	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o; // half period
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (8) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end
endmodule

`default_nettype wire

/* clkmgr_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module clkmgr_tb;
	import clkmgr_pkg::*;

	// op, arg, expected code, expected data, psen pulses seen so far
	typedef struct packed {
		opcode_t    op;
		cmd_arg_t   arg;
		rsp_code_t  code;
		rsp_data_t  data;
		logic [7:0] psen_total;
	} entry_t;

	logic     clk;
	logic     rst_n;
	logic     cmd_valid;
	opcode_t  cmd_op;
	cmd_arg_t cmd_arg;
	logic     cmd_credit;
	logic     rsp_credit;
	logic     rsp_valid;
	rsp_t     rsp;
	logic     locked;
	logic     psen;

	entry_t      tbl [$];
	logic [31:0] rng_state = 32'hb30c;
	int          errors = 0;
	int          entry_pass = 0;
	int          entry_fail = 0;
	int          sent = 0;
	int          credits_back = 0;
	int          rsp_seen = 0;
	int          psen_cnt = 0;

	tb_clk_src u_clk_src (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	clkmgr_top u_dut (
		.clk_i        (clk),
		.rst_n_i      (rst_n),
		.cmd_valid_i  (cmd_valid),
		.cmd_op_i     (cmd_op),
		.cmd_arg_i    (cmd_arg),
		.cmd_credit_o (cmd_credit),
		.rsp_credit_i (rsp_credit),
		.rsp_valid_o  (rsp_valid),
		.rsp_o        (rsp),
		.locked_o     (locked),
		.psen_o       (psen)
	);

	always @(posedge clk) begin
		if (cmd_credit) credits_back <= credits_back + 1;
		if (rsp_valid) rsp_seen <= rsp_seen + 1;
		if (psen) psen_cnt <= psen_cnt + 1;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////////////////////////

	task automatic load_table();
		tbl.push_back(entry_t'{OP_RESET,  8'h00, RC_OK,         14'h3000, 8'd0});
		tbl.push_back(entry_t'{OP_STATUS, 8'h00, RC_OK,         14'h3000, 8'd0});
		tbl.push_back(entry_t'{OP_SHIFT,  8'h05, RC_OK,         14'h3005, 8'd5});
		tbl.push_back(entry_t'{OP_SHIFT,  8'hfd, RC_OK,         14'h3002, 8'd8}); // -3
		tbl.push_back(entry_t'{OP_STATUS, 8'h00, RC_OK,         14'h3002, 8'd8});
		tbl.push_back(entry_t'{OP_RESET,  8'h03, RC_TIMEOUT,    14'h0802, 8'd8}); // mult off
		tbl.push_back(entry_t'{OP_SHIFT,  8'h04, RC_NOT_LOCKED, 14'h0802, 8'd8});
		tbl.push_back(entry_t'{OP_STATUS, 8'h00, RC_TIMEOUT,    14'h0802, 8'd8});
		tbl.push_back(entry_t'{OP_RESET,  8'h01, RC_OK,         14'h3002, 8'd8}); // mult path
		tbl.push_back(entry_t'{OP_STATUS, 8'h00, RC_OK,         14'h3002, 8'd8});
		tbl.push_back(entry_t'{OP_SHIFT,  8'h00, RC_OK,         14'h3002, 8'd8});
		tbl.push_back(entry_t'{OP_STATUS, 8'h00, RC_OK,         14'h3002, 8'd8});
	endtask

	// host side of the command channel, sends whenever a credit is held
	task automatic send_cmds();
		int   i;
		int   avail;
		i = 0;
		while (i < tbl.size()) begin
			@(posedge clk);
			avail = CMD_CREDITS + credits_back - sent;
			if (avail > CMD_CREDITS) begin
				$display("more command credits came back than commands were sent");
				errors++;
			end
			if (avail > 0) begin
				cmd_valid <= 1'b1;
				cmd_op    <= tbl[i].op;
				cmd_arg   <= tbl[i].arg;
				sent++;
				i++;
			end else begin
				cmd_valid <= 1'b0;
			end
		end
		@(posedge clk);
		cmd_valid <= 1'b0;
	endtask

	task automatic collect_rsps();
		entry_t  e;
		opcode_t op;
		int      delay;
		int      err_before;
		for (int i = 0; i < tbl.size(); i++) begin
			e = tbl[i];
			op = e.op;
			rng_state = xorshift32(rng_state);
			delay = int'(rng_state[2:0]); // 0 to 7 cycles
			repeat (delay) @(posedge clk);
			rsp_credit <= 1'b1;
			@(posedge clk);
			rsp_credit <= 1'b0;
			do @(posedge clk); while (!rsp_valid); // watchdog bounds this
			err_before = errors;
			check_val("rsp code", 32'(rsp[15:14]), 32'(e.code));
			check_val("rsp data", 32'(rsp[13:0]), 32'(e.data));
			check_val("locked_o", 32'(locked), 32'(e.data[13])); // main lock flag
			check_val("psen pulses", psen_cnt, 32'(e.psen_total));
			if (errors == err_before) begin
				entry_pass++;
				$display("entry %0d %s arg 0x%02h: ok", i, op.name(), e.arg);
			end else begin
				entry_fail++;
				$display("entry %0d %s arg 0x%02h: mismatch", i, op.name(), e.arg);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		cmd_valid  = 1'b0;
		cmd_op     = OP_STATUS;
		cmd_arg    = '0;
		rsp_credit = 1'b0;
		load_table();
		wait (rst_n === 1'b1);
		repeat (2) @(posedge clk);
		fork
			send_cmds();
			collect_rsps();
		join
		repeat (20) @(posedge clk); // nothing extra may arrive
		check_val("responses", rsp_seen, tbl.size());
		check_val("command credits", credits_back, tbl.size());
		$display("%0d entries: %0d passed, %0d failed, %0d errors",
			tbl.size(), entry_pass, entry_fail, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		wait (rst_n === 1'b1);
		repeat (tbl.size() * 400) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", tbl.size() * 400);
		$display("Regression failed");
		$finish;
	end
endmodule

`default_nettype wire

/* verilog.f */
clkmgr_pkg.sv
ps_if.sv
clk_gen_model.sv
phase_stepper.sv
lock_monitor.sv
clk_ctrl.sv
clkmgr_top.sv
clkmgr_asserts.sv
tb_clk_src.sv
clkmgr_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module clkmgr_tb \
	-f verilog.f -o clkmgr_sim \
	&& ./obj_dir/clkmgr_sim | tee sim.log \
	|| { echo "build or run error"; exit 1; }

grep -q "^Regression passed$" sim.log \
	&& echo "simulation PASS" \
	|| { echo "simulation FAIL"; exit 1; }
